// ==== hw/cpu_mem_pkg.sv ====
`default_nettype none

package cpu_mem_pkg;

	localparam int word_data_w = 32;                // Data word
	localparam int word_addr_w = 30;                // Word address, byte bits dropped
	localparam int reg_addr_w  = 5;                 // Register file index
	localparam int region_w    = 3;                 // Top address bits picking the target

	// Memory operation carried down from decode
	typedef enum logic [1:0] {
		mem_op_nop = 2'h0,                          // No memory access
		mem_op_ldw = 2'h1,                          // Load word
		mem_op_stw = 2'h2                           // Store word
	} mem_op_t;

	// Control register operation, untouched by this stage
	typedef enum logic [1:0] {
		ctrl_op_nop  = 2'h0,                        // Nothing
		ctrl_op_wrcr = 2'h1,                        // Write control register
		ctrl_op_exrt = 2'h2                         // Return from exception
	} ctrl_op_t;

	// Exception codes
	typedef enum logic [2:0] {
		isa_exp_no_exp     = 3'h0,                  // No exception
		isa_exp_ext_int    = 3'h1,                  // External interrupt
		isa_exp_undef_insn = 3'h2,                  // Undefined instruction
		isa_exp_overflow   = 3'h3,                  // Arithmetic overflow
		isa_exp_miss_align = 3'h4,                  // Misaligned load or store
		isa_exp_trap       = 3'h5,                  // Trap instruction
		isa_exp_prv_vio    = 3'h6                   // Privilege violation
	} isa_exp_t;

	// One word address seen two ways
	// raw drives the address buses
	// seg splits off the region used for routing
	typedef union packed {
		logic [word_addr_w-1:0] raw;                // Plain word address
		struct packed {
			logic [region_w-1:0]             region; // Target region
			logic [word_addr_w-region_w-1:0] offset; // Word inside the region
		} seg;
	} word_addr_u;

endpackage

`default_nettype wire

// ==== hw/mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
	input  logic                                     ex_en,          // Stage holds a valid op
	input  cpu_mem_pkg::mem_op_t                     ex_mem_op,      // Memory op
	input  logic [cpu_mem_pkg::word_data_w-1:0]      ex_mem_wr_data, // Store data
	input  logic [cpu_mem_pkg::word_data_w-1:0]      ex_out,         // ALU result as byte address
	input  logic [cpu_mem_pkg::word_data_w-1:0]      rd_data,        // Word back from bus_if
	output cpu_mem_pkg::word_addr_u                  addr,           // Word address
	output logic                                     as_n,           // Access strobe
	output logic                                     rw,             // High for read
	output logic [cpu_mem_pkg::word_data_w-1:0]      wr_data,        // Store data to bus_if
	output logic [cpu_mem_pkg::word_data_w-1:0]      out,            // Stage result
	output logic                                     miss_align      // Misaligned access
);
	import cpu_mem_pkg::*;

	localparam int byte_w = word_data_w - word_addr_w; // Byte offset bits

	logic aligned;                                  // Low address bits all zero

	assign aligned = (ex_out[byte_w-1:0] == '0);

	assign addr.raw = ex_out[word_data_w-1:byte_w]; // Drop byte offset
	assign wr_data  = ex_mem_wr_data;               // Store data passes as is

	always_comb begin
		as_n       = 1'b1;                          // Idle by default
		rw         = 1'b1;                          // Read unless a store
		out        = ex_out;                        // Non-load result
		miss_align = 1'b0;
		if (ex_en) begin
			case (ex_mem_op)
				mem_op_ldw: begin
					if (aligned) begin
						as_n = 1'b0;                // Fire the load
						out  = rd_data;             // Loaded word
					end else begin
						miss_align = 1'b1;          // No access made
					end
				end
				mem_op_stw: begin
					if (aligned) begin
						as_n = 1'b0;                // Fire the store
						rw   = 1'b0;                // Write
					end else begin
						miss_align = 1'b1;
					end
				end
				default: begin
					as_n = 1'b1;                    // No memory op
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_if #(
	parameter logic [cpu_mem_pkg::region_w-1:0] spm_region = 3'h0 // Region mapped to the SPM
) (
	input  logic                                clk,         // Clock
	input  logic                                reset,       // Sync reset
	input  logic                                stall,       // Pipeline stall
	input  logic                                flush,       // Pipeline flush
	input  cpu_mem_pkg::word_addr_u             addr,        // Access address
	input  logic                                as_n,        // Access strobe
	input  logic                                rw,          // High for read
	input  logic [cpu_mem_pkg::word_data_w-1:0] wr_data,     // Store data
	input  logic [cpu_mem_pkg::word_data_w-1:0] spm_rd_data, // SPM read word
	input  logic [cpu_mem_pkg::word_data_w-1:0] bus_rd_data, // Bus read word
	input  logic                                bus_rdy_n,   // Slave ready
	input  logic                                bus_grnt_n,  // Bus grant
	output logic                                busy,        // Bus access outstanding
	output logic [cpu_mem_pkg::word_data_w-1:0] rd_data,     // Word back to mem_ctrl
	output logic [cpu_mem_pkg::word_addr_w-1:0] spm_addr,    // SPM address
	output logic                                spm_as_n,    // SPM strobe
	output logic                                spm_rw,      // SPM read or write
	output logic [cpu_mem_pkg::word_data_w-1:0] spm_wr_data, // SPM store data
	output logic                                bus_req_n,   // Bus request
	output logic [cpu_mem_pkg::word_addr_w-1:0] bus_addr,    // Bus address
	output logic                                bus_as_n,    // Bus strobe
	output logic                                bus_rw,      // Bus read or write
	output logic [cpu_mem_pkg::word_data_w-1:0] bus_wr_data  // Bus store data
);
	import cpu_mem_pkg::*;

	localparam logic [1:0] st_idle   = 2'd0;    // Waiting for an access
	localparam logic [1:0] st_req    = 2'd1;    // Bus requested
	localparam logic [1:0] st_access = 2'd2;    // Granted, strobe out
	localparam logic [1:0] st_stall  = 2'd3;    // Done, waiting for stall to drop

	logic [1:0]             state;              // FSM state
	logic [word_data_w-1:0] rd_buf;             // Bus read word held across stall
	logic                   spm_sel;            // Address falls in the SPM region
	logic                   bus_hit;            // New access bound for the bus

	assign spm_sel = (addr.seg.region == spm_region);
	assign bus_hit = !as_n && !spm_sel && !flush;

	// SPM sees the request directly
	assign spm_addr    = addr.raw;
	assign spm_rw      = rw;
	assign spm_wr_data = wr_data;

	// Request goes out in the first cycle and stays until ready
	assign bus_req_n = !((state == st_idle && bus_hit) || state == st_req || state == st_access);

	always_comb begin
		rd_data  = '0;
		spm_as_n = 1'b1;
		busy     = 1'b0;
		case (state)
			st_idle: begin
				if (!flush && !as_n) begin
					if (spm_sel) begin
						if (!stall) begin
							spm_as_n = 1'b0;        // One cycle SPM access
							if (rw) rd_data = spm_rd_data;
						end
					end else begin
						busy = 1'b1;                // Bus access starts now
					end
				end
			end
			st_req: begin
				busy = 1'b1;
			end
			st_access: begin
				busy = 1'b1;                        // Still high in the ready cycle
				if (!bus_rdy_n && rw) rd_data = bus_rd_data;
			end
			default: begin
				if (rw) rd_data = rd_buf;           // Held word until stall drops
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state    <= st_idle;                    // Flush aborts any bus access
			bus_as_n <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					if (bus_hit) state <= st_req;
				end
				st_req: begin
					if (!bus_grnt_n) begin
						state    <= st_access;
						bus_as_n <= 1'b0;           // Strobe held until ready
					end
				end
				st_access: begin
					if (!bus_rdy_n) begin
						state    <= st_stall;
						bus_as_n <= 1'b1;
					end
				end
				default: begin
					if (!stall) state <= st_idle;   // Result taken by mem_reg
				end
			endcase
		end
	end

	// Bus payload and read buffer
	always_ff @(posedge clk) begin
		if (state == st_req && !bus_grnt_n) begin
			bus_addr    <= addr.raw;
			bus_rw      <= rw;
			bus_wr_data <= wr_data;
		end
		if (state == st_access && !bus_rdy_n && rw) begin
			rd_buf <= bus_rd_data;                  // Keep read word
		end
	end

	// Only one target is strobed at a time
	a_one_target: assert property (@(posedge clk) disable iff (reset)
		!(!spm_as_n && !bus_as_n));

	// Bus strobe stays inside the request window
	a_strobe_in_req: assert property (@(posedge clk) disable iff (reset)
		!bus_as_n |-> !bus_req_n);

endmodule

`default_nettype wire

// ==== hw/mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_reg (
	input  logic                                clk,          // Clock
	input  logic                                reset,        // Sync reset
	input  logic                                stall,        // Hold contents
	input  logic                                flush,        // Cancel stage
	input  logic [cpu_mem_pkg::word_data_w-1:0] out,          // Stage result
	input  logic                                miss_align,   // Misaligned access
	input  logic [cpu_mem_pkg::word_addr_w-1:0] ex_pc,        // PC
	input  logic                                ex_en,        // Valid op
	input  logic                                ex_br_flag,   // Branch flag
	input  cpu_mem_pkg::ctrl_op_t               ex_ctrl_op,   // Control reg op
	input  logic [cpu_mem_pkg::reg_addr_w-1:0]  ex_dst_addr,  // Destination register
	input  logic                                ex_gpr_we_n,  // GPR write enable
	input  cpu_mem_pkg::isa_exp_t               ex_exp_code,  // Incoming exception
	output logic [cpu_mem_pkg::word_addr_w-1:0] mem_pc,       // PC
	output logic                                mem_en,       // Valid op
	output logic                                mem_br_flag,  // Branch flag
	output cpu_mem_pkg::ctrl_op_t               mem_ctrl_op,  // Control reg op
	output logic [cpu_mem_pkg::reg_addr_w-1:0]  mem_dst_addr, // Destination register
	output logic                                mem_gpr_we_n, // GPR write enable
	output cpu_mem_pkg::isa_exp_t               mem_exp_code, // Exception code
	output logic [cpu_mem_pkg::word_data_w-1:0] mem_out       // Stage result
);
	import cpu_mem_pkg::*;

	// Control fields
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			mem_en       <= 1'b0;
			mem_br_flag  <= 1'b0;
			mem_ctrl_op  <= ctrl_op_nop;
			mem_gpr_we_n <= 1'b1;                   // No register write
			mem_exp_code <= isa_exp_no_exp;
		end else if (!stall) begin
			mem_en      <= ex_en;
			mem_ctrl_op <= ex_ctrl_op;
			if (miss_align) begin
				mem_br_flag  <= 1'b0;               // Kill branch
				mem_gpr_we_n <= 1'b1;               // Kill write back
				mem_exp_code <= isa_exp_miss_align;
			end else begin
				mem_br_flag  <= ex_br_flag;
				mem_gpr_we_n <= ex_gpr_we_n;
				mem_exp_code <= ex_exp_code;
			end
		end
	end

	// Payload fields
	always_ff @(posedge clk) begin
		if (!stall) begin
			mem_pc       <= ex_pc;
			mem_dst_addr <= ex_dst_addr;
			mem_out      <= out;                    // Load word or ALU result
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
	parameter logic [cpu_mem_pkg::region_w-1:0] spm_region = 3'h0 // SPM region code
) (
	input  logic                                clk,            // Clock
	input  logic                                reset,          // Sync reset
	input  logic                                stall,          // Pipeline stall
	input  logic                                flush,          // Pipeline flush
	output logic                                busy,           // Bus access outstanding
	output logic [cpu_mem_pkg::word_data_w-1:0] fwd_data,       // Bypass value
	input  logic [cpu_mem_pkg::word_data_w-1:0] spm_rd_data,    // SPM read word
	output logic [cpu_mem_pkg::word_addr_w-1:0] spm_addr,       // SPM address
	output logic                                spm_as_n,       // SPM strobe
	output logic                                spm_rw,         // SPM read or write
	output logic [cpu_mem_pkg::word_data_w-1:0] spm_wr_data,    // SPM store data
	input  logic [cpu_mem_pkg::word_data_w-1:0] bus_rd_data,    // Bus read word
	input  logic                                bus_rdy_n,      // Slave ready
	input  logic                                bus_grnt_n,     // Bus grant
	output logic                                bus_req_n,      // Bus request
	output logic [cpu_mem_pkg::word_addr_w-1:0] bus_addr,       // Bus address
	output logic                                bus_as_n,       // Bus strobe
	output logic                                bus_rw,         // Bus read or write
	output logic [cpu_mem_pkg::word_data_w-1:0] bus_wr_data,    // Bus store data
	input  logic [cpu_mem_pkg::word_addr_w-1:0] ex_pc,          // EX/MEM PC
	input  logic                                ex_en,          // EX/MEM valid
	input  logic                                ex_br_flag,     // EX/MEM branch flag
	input  cpu_mem_pkg::mem_op_t                ex_mem_op,      // EX/MEM memory op
	input  logic [cpu_mem_pkg::word_data_w-1:0] ex_mem_wr_data, // EX/MEM store data
	input  cpu_mem_pkg::ctrl_op_t               ex_ctrl_op,     // EX/MEM control op
	input  logic [cpu_mem_pkg::reg_addr_w-1:0]  ex_dst_addr,    // EX/MEM destination
	input  logic                                ex_gpr_we_n,    // EX/MEM GPR write
	input  cpu_mem_pkg::isa_exp_t               ex_exp_code,    // EX/MEM exception
	input  logic [cpu_mem_pkg::word_data_w-1:0] ex_out,         // EX/MEM result
	output logic [cpu_mem_pkg::word_addr_w-1:0] mem_pc,         // MEM/WB PC
	output logic                                mem_en,         // MEM/WB valid
	output logic                                mem_br_flag,    // MEM/WB branch flag
	output cpu_mem_pkg::ctrl_op_t               mem_ctrl_op,    // MEM/WB control op
	output logic [cpu_mem_pkg::reg_addr_w-1:0]  mem_dst_addr,   // MEM/WB destination
	output logic                                mem_gpr_we_n,   // MEM/WB GPR write
	output cpu_mem_pkg::isa_exp_t               mem_exp_code,   // MEM/WB exception
	output logic [cpu_mem_pkg::word_data_w-1:0] mem_out         // MEM/WB result
);
	import cpu_mem_pkg::*;

	word_addr_u             addr;                   // Access address
	logic                   as_n;                   // Access strobe
	logic                   rw;                     // Read or write
	logic [word_data_w-1:0] wr_data;                // Store data
	logic [word_data_w-1:0] rd_data;                // Read word
	logic [word_data_w-1:0] out;                    // Stage result
	logic                   miss_align;             // Misaligned access

	assign fwd_data = out;                          // Bypass to earlier stages

	mem_ctrl mem_ctrl_inst (
		.ex_en          (ex_en),
		.ex_mem_op      (ex_mem_op),
		.ex_mem_wr_data (ex_mem_wr_data),
		.ex_out         (ex_out),
		.rd_data        (rd_data),
		.addr           (addr),
		.as_n           (as_n),
		.rw             (rw),
		.wr_data        (wr_data),
		.out            (out),
		.miss_align     (miss_align)
	);

	bus_if #(
		.spm_region (spm_region)
	) bus_if_inst (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.flush       (flush),
		.addr        (addr),
		.as_n        (as_n),
		.rw          (rw),
		.wr_data     (wr_data),
		.spm_rd_data (spm_rd_data),
		.bus_rd_data (bus_rd_data),
		.bus_rdy_n   (bus_rdy_n),
		.bus_grnt_n  (bus_grnt_n),
		.busy        (busy),
		.rd_data     (rd_data),
		.spm_addr    (spm_addr),
		.spm_as_n    (spm_as_n),
		.spm_rw      (spm_rw),
		.spm_wr_data (spm_wr_data),
		.bus_req_n   (bus_req_n),
		.bus_addr    (bus_addr),
		.bus_as_n    (bus_as_n),
		.bus_rw      (bus_rw),
		.bus_wr_data (bus_wr_data)
	);

	mem_reg mem_reg_inst (
		.clk          (clk),
		.reset        (reset),
		.stall        (stall),
		.flush        (flush),
		.out          (out),
		.miss_align   (miss_align),
		.ex_pc        (ex_pc),
		.ex_en        (ex_en),
		.ex_br_flag   (ex_br_flag),
		.ex_ctrl_op   (ex_ctrl_op),
		.ex_dst_addr  (ex_dst_addr),
		.ex_gpr_we_n  (ex_gpr_we_n),
		.ex_exp_code  (ex_exp_code),
		.mem_pc       (mem_pc),
		.mem_en       (mem_en),
		.mem_br_flag  (mem_br_flag),
		.mem_ctrl_op  (mem_ctrl_op),
		.mem_dst_addr (mem_dst_addr),
		.mem_gpr_we_n (mem_gpr_we_n),
		.mem_exp_code (mem_exp_code),
		.mem_out      (mem_out)
	);

endmodule

`default_nettype wire

// ==== test/mem_stage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_chk (
	input  logic        clk,          // Clock
	input  logic        active,       // Row inputs on the DUT
	input  logic        check,        // Compare MEM/WB now
	input  logic        rst_chk,      // Compare reset values now
	input  logic        fwd_chk,      // fwd_data must equal exp_out
	input  logic        is_flush,     // Row ends in a flush
	input  logic [1:0]  exp_target,   // 0 none, 1 SPM, 2 bus
	input  logic [31:0] exp_out,      // Expected mem_out
	input  logic [2:0]  exp_code,     // Expected exception
	input  logic        exp_en,       // Expected mem_en
	input  logic        exp_we_n,     // Expected mem_gpr_we_n
	input  logic        exp_br,       // Expected mem_br_flag
	input  logic [29:0] exp_pc,       // Expected mem_pc
	input  logic [4:0]  exp_dst,      // Expected mem_dst_addr
	input  logic [1:0]  exp_ctrl,     // Expected mem_ctrl_op
	input  logic [29:0] exp_baddr,    // Expected word address
	input  logic        exp_rw,       // Expected bus_rw or spm_rw
	input  logic [31:0] exp_wdata,    // Expected store data
	input  logic        busy,
	input  logic [31:0] fwd_data,
	input  logic [29:0] spm_addr,
	input  logic        spm_as_n,
	input  logic        spm_rw,
	input  logic [31:0] spm_wr_data,
	input  logic        bus_req_n,
	input  logic        bus_as_n,
	input  logic [29:0] bus_addr,
	input  logic        bus_rw,
	input  logic [31:0] bus_wr_data,
	input  logic [29:0] mem_pc,
	input  logic        mem_en,
	input  logic        mem_br_flag,
	input  logic [1:0]  mem_ctrl_op,
	input  logic [4:0]  mem_dst_addr,
	input  logic        mem_gpr_we_n,
	input  logic [2:0]  mem_exp_code,
	input  logic [31:0] mem_out,
	output int          errors,       // All mismatches
	output int          tests         // Rows finished
);
	int   test_errs = 0;              // Mismatches in this row
	logic saw_spm   = 1'b0;           // SPM strobe seen
	logic saw_req   = 1'b0;           // Bus request seen
	logic saw_bus   = 1'b0;           // Bus strobe seen
	logic was_busy  = 1'b0;           // Stall high at the last edge of a row

	initial errors = 0;
	initial tests  = 0;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("Error: %s expected %h got %h", name, exp, got);
			test_errs++;
		end
	endtask

	always @(posedge clk) begin
		if (rst_chk) begin                        // Everything idle after reset
			compare("mem_en", 0, mem_en);
			compare("mem_gpr_we_n", 1, mem_gpr_we_n);
			compare("mem_exp_code", 0, mem_exp_code);
			compare("busy", 0, busy);
			compare("bus_req_n", 1, bus_req_n);
			compare("bus_as_n", 1, bus_as_n);
			compare("spm_as_n", 1, spm_as_n);
			$display("reset test %s", (test_errs == 0) ? "ok" : "failed");
			errors += test_errs;
			test_errs = 0;
		end
		if (active) begin
			if (!spm_as_n) begin                  // SPM payload while strobed
				saw_spm = 1'b1;
				compare("spm_addr", exp_baddr, spm_addr);
				compare("spm_rw", exp_rw, spm_rw);
				if (!exp_rw) compare("spm_wr_data", exp_wdata, spm_wr_data);
			end
			if (!bus_req_n) saw_req = 1'b1;
			if (!bus_as_n) begin                  // Payload while strobed
				saw_bus = 1'b1;
				compare("bus_addr", exp_baddr, bus_addr);
				compare("bus_rw", exp_rw, bus_rw);
				if (!exp_rw) compare("bus_wr_data", exp_wdata, bus_wr_data);
			end
			if (was_busy) begin                   // Idle entry held through the stall
				compare("mem_en", 0, mem_en);
				compare("mem_out", 0, mem_out);
			end
			if (fwd_chk) compare("fwd_data", exp_out, fwd_data);
		end
		was_busy = active && busy;
		if (check) begin
			compare("mem_en", exp_en, mem_en);
			compare("mem_gpr_we_n", exp_we_n, mem_gpr_we_n);
			compare("mem_br_flag", exp_br, mem_br_flag);
			compare("mem_exp_code", exp_code, mem_exp_code);
			if (is_flush) begin
				compare("bus_req_n", 1, bus_req_n);   // Request dropped
			end else begin
				compare("mem_out", exp_out, mem_out);
				compare("mem_pc", exp_pc, mem_pc);
				compare("mem_dst_addr", exp_dst, mem_dst_addr);
				compare("mem_ctrl_op", exp_ctrl, mem_ctrl_op);
			end
			if ((exp_target == 2'd0 && (saw_spm || saw_bus)) ||
				(exp_target == 2'd1 && (!saw_spm || saw_req)) ||
				(exp_target == 2'd2 && !saw_bus)) begin
				$display("Access went to the wrong target: expected %0d, spm %0b bus %0b",
					exp_target, saw_spm, saw_bus);
				test_errs++;
			end
			$display("test %0d %s", tests, (test_errs == 0) ? "ok" : "failed");
			errors += test_errs;
			tests++;
			test_errs = 0;
			saw_spm = 1'b0;
			saw_req = 1'b0;
			saw_bus = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;
	import cpu_mem_pkg::*;

	localparam int n_rows    = 10;
	localparam int max_dly   = 8;                 // Longest grant or ready delay
	localparam int cyc_limit = n_rows * (2 * max_dly + 8) + 40;

	logic clk, reset, stall, flush, busy, spm_as_n, spm_rw, bus_req_n, bus_as_n, bus_rw;
	logic bus_rdy_n, bus_grnt_n, ex_en, ex_br_flag, ex_gpr_we_n;
	logic mem_en, mem_br_flag, mem_gpr_we_n;
	logic [31:0] fwd_data, spm_rd_data, spm_wr_data, bus_rd_data, bus_wr_data;
	logic [31:0] ex_mem_wr_data, ex_out, mem_out;
	logic [29:0] spm_addr, bus_addr, ex_pc, mem_pc;
	logic [4:0]  ex_dst_addr, mem_dst_addr;
	mem_op_t  ex_mem_op;
	ctrl_op_t ex_ctrl_op, mem_ctrl_op;
	isa_exp_t ex_exp_code, mem_exp_code;

	// Stimulus table
	mem_op_t     op_t[n_rows];
	logic [31:0] addr_t[n_rows], wdata_t[n_rows], out_t[n_rows];
	logic        we_t[n_rows], flush_t[n_rows];
	isa_exp_t    expin_t[n_rows], code_t[n_rows];
	logic [1:0]  target_t[n_rows];
	int          gdly_t[n_rows], rdly_t[n_rows];

	logic active, check, rst_chk, fwd_chk, is_flush, exp_en, exp_we_n, exp_rw, exp_br;
	logic [1:0]  exp_target, exp_ctrl;
	logic [31:0] exp_out, exp_wdata;
	logic [2:0]  exp_code;
	logic [29:0] exp_pc, exp_baddr;
	logic [4:0]  exp_dst;
	int errors, tests, cycles, cur_gdly, cur_rdly, g_cnt, r_cnt;
	logic r_done, taken;
	logic [31:0] lfsr = 32'he0b850db;
	logic [31:0] spm_mem[16], bus_mem[16];        // Target models

	assign stall = busy;                          // Controller holds stall on busy

	function automatic logic [31:0] fill_word(input logic [29:0] a);
		return {a, 2'b01} ^ 32'hc3c3_3c3c;        // Every address bit shows
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];                // One step per bit
		end
	endtask

	task automatic set_row(input int i, input mem_op_t op, input logic [31:0] a, d,
		input logic we, input isa_exp_t ei, input logic [31:0] eo, input isa_exp_t ec,
		input logic [1:0] tg, input logic fl);
		op_t[i]     = op;
		addr_t[i]   = a;
		wdata_t[i]  = d;
		we_t[i]     = we;
		expin_t[i]  = ei;
		out_t[i]    = eo;
		code_t[i]   = ec;
		target_t[i] = tg;
		flush_t[i]  = fl;
		take_bits(2, gdly_t[i]);
		take_bits(2, rdly_t[i]);
	endtask

	mem_stage mem_stage_inst (.*);

	mem_stage_chk chk_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign spm_rd_data = spm_mem[spm_addr[3:0]]; // Same-cycle read
	always @(posedge clk) begin
		if (!spm_as_n && !spm_rw) spm_mem[spm_addr[3:0]] <= spm_wr_data;
	end

	// Bus slave grants and readies after the row's delays
	always begin
		@(negedge clk);
		#2;
		if (bus_req_n) begin
			g_cnt      = 0;
			r_cnt      = 0;
			r_done     = 1'b0;
			bus_grnt_n = 1'b1;
			bus_rdy_n  = 1'b1;
		end else begin
			if (g_cnt >= cur_gdly) bus_grnt_n = 1'b0;
			else g_cnt++;
			bus_rdy_n = 1'b1;
			if (!bus_as_n && !r_done) begin
				if (r_cnt >= cur_rdly) begin
					bus_rdy_n   = 1'b0;            // One-cycle ready
					bus_rd_data = bus_mem[bus_addr[3:0]];
					if (!bus_rw) bus_mem[bus_addr[3:0]] = bus_wr_data;
					r_done = 1'b1;
				end else begin
					r_cnt++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cyc_limit) begin
			$display("Timeout: run went past %0d cycles", cyc_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic drive_idle();
		ex_en          = 1'b0;
		ex_mem_op      = mem_op_nop;
		ex_out         = '0;
		ex_mem_wr_data = '0;
		ex_br_flag     = 1'b0;
		ex_gpr_we_n    = 1'b1;
		ex_exp_code    = isa_exp_no_exp;
		ex_ctrl_op     = ctrl_op_nop;
		ex_pc          = '0;
		ex_dst_addr    = '0;
		active         = 1'b0;
	endtask

	task automatic run_row(input int i);
		logic miss;
		miss = (op_t[i] != mem_op_nop) && (addr_t[i][1:0] != 2'b00);
		@(negedge clk);
		ex_en          = 1'b1;
		ex_mem_op      = op_t[i];
		ex_out         = addr_t[i];
		ex_mem_wr_data = wdata_t[i];
		ex_gpr_we_n    = we_t[i];
		ex_exp_code    = expin_t[i];
		ex_pc          = 30'h100 + 30'(i);
		ex_dst_addr    = 5'(i + 1);
		ex_br_flag     = i[0];                       // Odd rows carry a branch
		ex_ctrl_op     = (op_t[i] == mem_op_nop) ? ctrl_op_wrcr : ctrl_op_nop;
		cur_gdly       = flush_t[i] ? max_dly : gdly_t[i];
		cur_rdly       = rdly_t[i];
		exp_out        = out_t[i];
		exp_code       = code_t[i];
		exp_target     = target_t[i];
		exp_en         = !flush_t[i];
		exp_we_n       = (miss || flush_t[i]) ? 1'b1 : we_t[i];
		exp_br         = (miss || flush_t[i]) ? 1'b0 : ex_br_flag;
		exp_pc         = ex_pc;
		exp_dst        = ex_dst_addr;
		exp_ctrl       = ex_ctrl_op;
		exp_baddr      = addr_t[i][31:2];
		exp_rw         = (op_t[i] == mem_op_ldw);
		exp_wdata      = wdata_t[i];
		is_flush       = flush_t[i];
		fwd_chk        = (op_t[i] != mem_op_ldw) || miss; // Non-load result is ex_out
		active         = 1'b1;
		if (flush_t[i]) begin
			repeat (3) @(posedge clk);               // Still waiting for grant
			@(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
		end else begin
			taken = 1'b0;
			while (!taken) begin                     // Until an edge with stall low
				#1;
				taken = !busy;
				@(posedge clk);
				if (!taken) @(negedge clk);
			end
			@(negedge clk);
		end
		drive_idle();
		check = 1'b1;
		@(negedge clk);
		check = 1'b0;
	endtask

	initial begin
		reset       = 1'b1;
		flush       = 1'b0;
		check       = 1'b0;
		rst_chk     = 1'b0;
		fwd_chk     = 1'b0;
		is_flush    = 1'b0;
		bus_grnt_n  = 1'b1;
		bus_rdy_n   = 1'b1;
		bus_rd_data = '0;
		cycles      = 0;
		cur_gdly    = 0;
		cur_rdly    = 0;
		drive_idle();
		for (int k = 0; k < 16; k++) begin
			spm_mem[k] = fill_word(30'(k));
			bus_mem[k] = fill_word({3'h1, 27'(k)});
		end
		set_row(0, mem_op_stw, 32'h0000_0010, 32'ha5a5_1234, 1'b1, isa_exp_no_exp,
			32'h0000_0010, isa_exp_no_exp, 2'd1, 1'b0);
		set_row(1, mem_op_ldw, 32'h0000_0010, 32'h0, 1'b0, isa_exp_no_exp,
			32'ha5a5_1234, isa_exp_no_exp, 2'd1, 1'b0);
		set_row(2, mem_op_ldw, 32'h2000_0004, 32'h0, 1'b0, isa_exp_no_exp,
			fill_word(30'h0800_0001), isa_exp_no_exp, 2'd2, 1'b0);
		set_row(3, mem_op_stw, 32'h2000_0008, 32'h0bad_f00d, 1'b1, isa_exp_no_exp,
			32'h2000_0008, isa_exp_no_exp, 2'd2, 1'b0);
		set_row(4, mem_op_ldw, 32'h2000_0008, 32'h0, 1'b0, isa_exp_no_exp,
			32'h0bad_f00d, isa_exp_no_exp, 2'd2, 1'b0);
		set_row(5, mem_op_ldw, 32'h2000_0006, 32'h0, 1'b0, isa_exp_no_exp,
			32'h2000_0006, isa_exp_miss_align, 2'd0, 1'b0);
		set_row(6, mem_op_stw, 32'h0000_0011, 32'h1111_2222, 1'b1, isa_exp_no_exp,
			32'h0000_0011, isa_exp_miss_align, 2'd0, 1'b0);
		set_row(7, mem_op_nop, 32'h1234_5678, 32'h0, 1'b0, isa_exp_overflow,
			32'h1234_5678, isa_exp_overflow, 2'd0, 1'b0);
		set_row(8, mem_op_ldw, 32'h2000_000c, 32'h0, 1'b0, isa_exp_no_exp,
			fill_word(30'h0800_0003), isa_exp_no_exp, 2'd2, 1'b0);
		set_row(9, mem_op_ldw, 32'h2000_000c, 32'h0, 1'b0, isa_exp_no_exp,
			32'h0, isa_exp_no_exp, 2'd0, 1'b1);
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		rst_chk = 1'b1;
		@(negedge clk);
		rst_chk = 1'b0;
		for (int i = 0; i < n_rows; i++) run_row(i);
		@(negedge clk);
		$display("Done: %0d tests, %0d errors", tests, errors);
		if (errors == 0 && tests == n_rows) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpu_mem.f ====
hw/cpu_mem_pkg.sv
hw/mem_ctrl.sv
hw/bus_if.sv
hw/mem_reg.sv
hw/mem_stage.sv
test/mem_stage_chk.sv
test/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_mem

sources:
  - files:
      - hw/cpu_mem_pkg.sv
      - hw/mem_ctrl.sv
      - hw/bus_if.sv
      - hw/mem_reg.sv
      - hw/mem_stage.sv
  - target: test
    files:
      - test/mem_stage_chk.sv
      - test/mem_stage_tb.sv
